/* Makefile */
VERILATOR   ?= verilator
TOP         ?= bdDecoderTb
FILELIST    ?= tb.f
OBJDIR      ?= obj_dir
VFLAGS      ?= --binary --assert -j 0
ERROR_LIMIT ?= 100
PASS_MSG    ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

/* bdHornDecoder/bdHornDecoder.sv */
`timescale 1ns/1ps
`include "bdDecoder_params.svh"

module bdHornDecoder (
  input  logic                     inValid,
  input  bdDecoderPkg::bdWord_t    inWord,
  output logic                     inAck,
  output logic                     decValid,
  output bdDecoderPkg::leafCode_t  decCode,
  output bdDecoderPkg::bdPayload_t decPayload,
  input  logic                     decAck
);

  import bdDecoderPkg::*;

  //////////////////////////////////////////////////
  // routing table
  //////////////////////////////////////////////////
  // leaf            route     len
  // DumpAm          101000    6
  // DumpMm          101001    6
  // DumpPat         10101     5
  // DumpPostFifo0   101110    6
  // DumpPostFifo1   101111    6
  // DumpPreFifo     101101    6
  // DumpTat0        1000      4
  // DumpTat1        1001      4
  // Nrni            11        2
  // Ovflw0          1011000   7
  // Ovflw1          1011001   7
  // RoAcc           01        2
  // RoTat           00        2

  // longest route in the table
  localparam int RouteMaxLen = 7;

  // routes left-aligned in a 7-bit field, unused low bits zero
  localparam logic [0:`BD_NUM_LEAVES-1][RouteMaxLen-1:0] RouteTop = '{
    7'b1010000, 7'b1010010, 7'b1010100, 7'b1011100, 7'b1011110,
    7'b1011010, 7'b1000000, 7'b1001000, 7'b1100000, 7'b1011000,
    7'b1011001, 7'b0100000, 7'b0000000
  };

  // number of route bits per leaf
  localparam logic [0:`BD_NUM_LEAVES-1][2:0] RouteLen = '{
    3'd6, 3'd6, 3'd5, 3'd6, 3'd6, 3'd6, 3'd4, 3'd4, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2
  };

  //////////////////////////////////////////////////
  // parallel route match
  //////////////////////////////////////////////////
  logic [`BD_NUM_LEAVES-1:0][`BD_WORD_W-1:0] routeMask;
  logic [`BD_NUM_LEAVES-1:0]                 hit;
  bdLeaf_t                                   leaf;
  bdWord_t                                   keepMask;
  bdWord_t                                   maskedWord;

  for (genvar i = 0; i < `BD_NUM_LEAVES; i++) begin : gRoute
    // ones over the route bits only
    assign routeMask[i] = ~({`BD_WORD_W{1'b1}} >> RouteLen[i]);
    // masked top bits against the aligned route
    assign hit[i] = ((inWord & routeMask[i]) ==
                     {RouteTop[i], {(`BD_WORD_W-RouteMaxLen){1'b0}}});
  end

  //////////////////////////////////////////////////
  // priority encode, lowest leaf index wins
  //////////////////////////////////////////////////
  always_comb begin
    // no match keeps every bit
    leaf     = Invalid;
    keepMask = '1;
    // walk downward so the lowest hit is written last
    for (int i = `BD_NUM_LEAVES-1; i >= 0; i--) begin
      if (hit[i]) begin
        leaf     = bdLeaf_t'(i);
        keepMask = ~routeMask[i];
      end
    end
  end

  // strip route, drop the top two bits
  assign maskedWord = inWord & keepMask;
  assign decPayload = maskedWord[`BD_PAYLOAD_W-1:0];
  assign decCode    = leafCode_t'(leaf);

  // handshake passes straight through
  assign decValid = inValid;
  assign inAck    = decAck;

endmodule

/* bdHornDeserializer/bdHornDeserializer.sv */
`timescale 1ns/1ps
`include "bdDecoder_params.svh"

module bdHornDeserializer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      decValid,
  input  bdDecoderPkg::leafCode_t   decCode,
  input  bdDecoderPkg::bdPayload_t  decPayload,
  output logic                      decAck,
  output logic                      outValid,
  output bdDecoderPkg::leafCode_t   outCode,
  output bdDecoderPkg::outPayload_t outPayload,
  input  logic                      outAck
);

  import bdDecoderPkg::*;

  // code above payload on the merged streams
  localparam int MergeW = `BD_CODE_W + `BD_OUT_PAYLOAD_W;

  logic              isAm;
  logic              chunkValid;
  logic              chunkAck;
  amChunk_t          chunk;
  logic              otherValid;
  logic              otherAck;
  logic [MergeW-1:0] otherData;
  logic              amWordValid;
  logic              amWordAck;
  outPayload_t       amWord;
  logic [MergeW-1:0] amData;
  logic [MergeW-1:0] mergedData;

  //////////////////////////////////////////////////
  // split AM chunks from the rest
  //////////////////////////////////////////////////
  assign isAm       = (decCode == leafCode_t'(DumpAm));
  assign chunkValid = decValid && isAm;
  // one AM chunk rides in the low payload bits
  assign chunk      = decPayload[`BD_AM_CHUNK_W-1:0];
  assign otherValid = decValid && !isAm;
  // zero-extended up to the output payload
  assign otherData  = {decCode, outPayload_t'(decPayload)};
  // ack from whichever side the word was steered to
  assign decAck     = isAm ? chunkAck : otherAck;

  // AM pair assembly
  wordDeserializer amDeser (
    .clk       (clk),
    .rst       (rst),
    .chunkValid(chunkValid),
    .chunk     (chunk),
    .chunkAck  (chunkAck),
    .wordValid (amWordValid),
    .word      (amWord),
    .wordAck   (amWordAck)
  );

  // joined word gets its code back
  assign amData = {leafCode_t'(DumpAm), amWord};

  //////////////////////////////////////////////////
  // merge back into one stream
  //////////////////////////////////////////////////
  streamMerge #(.DataW(MergeW)) merge (
    .clk     (clk),
    .rst     (rst),
    .aValid  (otherValid),
    .aData   (otherData),
    .aAck    (otherAck),
    .bValid  (amWordValid),
    .bData   (amData),
    .bAck    (amWordAck),
    .outValid(outValid),
    .outData (mergedData),
    .outAck  (outAck)
  );

  assign {outCode, outPayload} = mergedData;

endmodule

/* common/bdDecoderPkg.sv */
`include "bdDecoder_params.svh"

package bdDecoderPkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // word as it leaves the funnel
  typedef logic [`BD_WORD_W-1:0] bdWord_t;
  // route bits cleared, cut down
  typedef logic [`BD_PAYLOAD_W-1:0] bdPayload_t;
  // half of an AM word
  typedef logic [`BD_AM_CHUNK_W-1:0] amChunk_t;
  // payload on the decoder output
  typedef logic [`BD_OUT_PAYLOAD_W-1:0] outPayload_t;
  // leaf code as carried on wires
  typedef logic [`BD_CODE_W-1:0] leafCode_t;

  //////////////////////////////////////////////////
  // leaves in table order, value is the code
  //////////////////////////////////////////////////
  typedef enum logic [`BD_CODE_W-1:0] {
    DumpAm = 0,
    DumpMm,
    DumpPat,
    DumpPostFifo0,
    DumpPostFifo1,
    DumpPreFifo,
    DumpTat0,
    DumpTat1,
    Nrni,
    Ovflw0,
    Ovflw1,
    RoAcc,
    RoTat,
    Invalid
  } bdLeaf_t;

  // AM chunk assembly
  typedef enum logic [1:0] {WaitLow, WaitHigh, Full} deserState_t;

endpackage

/* common/bdDecoder_params.svh */
`ifndef BD_DECODER_PARAMS_SVH
`define BD_DECODER_PARAMS_SVH

//////////////////////////////////////////////////
// funnel word geometry, fixed by the chip
//////////////////////////////////////////////////

// raw word out of the funnel, route in the top bits
`define BD_WORD_W 34

// widest single-chunk payload after route removal
`define BD_PAYLOAD_W 32

// AM diagnostic words arrive as two of these
`define BD_AM_CHUNK_W 19

// output payload, sized for a joined AM word
`define BD_OUT_PAYLOAD_W 38

// leaf code, 13 leaves plus the invalid code
`define BD_CODE_W 4
`define BD_NUM_LEAVES 13

`endif

/* rtl/bdDecoder.sv */
`timescale 1ns/1ps

module bdDecoder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inValid,
  input  bdDecoderPkg::bdWord_t     inWord,
  output logic                      inAck,
  output logic                      outValid,
  output bdDecoderPkg::leafCode_t   outCode,
  output bdDecoderPkg::outPayload_t outPayload,
  input  logic                      outAck
);

  import bdDecoderPkg::*;

  // decoded word between the two stages
  logic       decValid;
  logic       decAck;
  leafCode_t  decCode;
  bdPayload_t decPayload;

  // route match, no state
  bdHornDecoder hornDec (
    .inValid   (inValid),
    .inWord    (inWord),
    .inAck     (inAck),
    .decValid  (decValid),
    .decCode   (decCode),
    .decPayload(decPayload),
    .decAck    (decAck)
  );

  // AM join and re-merge
  bdHornDeserializer hornDeser (
    .clk       (clk),
    .rst       (rst),
    .decValid  (decValid),
    .decCode   (decCode),
    .decPayload(decPayload),
    .decAck    (decAck),
    .outValid  (outValid),
    .outCode   (outCode),
    .outPayload(outPayload),
    .outAck    (outAck)
  );

endmodule

/* rtl/streamMerge.sv */
`timescale 1ns/1ps

module streamMerge #(
  parameter int DataW = 42
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             aValid,
  input  logic [DataW-1:0] aData,
  output logic             aAck,
  input  logic             bValid,
  input  logic [DataW-1:0] bData,
  output logic             bAck,
  output logic             outValid,
  output logic [DataW-1:0] outData,
  input  logic             outAck
);

  logic             holdValid;
  logic [DataW-1:0] holdData;
  // set when b was served last
  logic             lastB;
  logic             canLoad;
  logic             pickA;
  logic             pickB;

  // register empty or leaving this edge
  assign canLoad = !holdValid || outAck;

  //////////////////////////////////////////////////
  // round-robin select
  //////////////////////////////////////////////////
  always_comb begin
    pickA = 1'b0;
    pickB = 1'b0;
    if (canLoad) begin
      if (aValid && bValid) begin
        // both pending, take the one not served last
        pickA = lastB;
        pickB = !lastB;
      end else begin
        pickA = aValid;
        pickB = bValid;
      end
    end
  end

  assign aAck = pickA;
  assign bAck = pickB;

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      holdValid <= 1'b0;
      lastB     <= 1'b0;
    end else if (canLoad) begin
      holdValid <= pickA || pickB;
      if (pickA) lastB <= 1'b0;
      if (pickB) lastB <= 1'b1;
    end
  end

  // payload, loaded only on a pick
  always_ff @(posedge clk) begin
    if (pickA) begin
      holdData <= aData;
    end else if (pickB) begin
      holdData <= bData;
    end
  end

  assign outValid = holdValid;
  assign outData  = holdData;

endmodule

/* rtl/wordDeserializer.sv */
`timescale 1ns/1ps

module wordDeserializer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      chunkValid,
  input  bdDecoderPkg::amChunk_t    chunk,
  output logic                      chunkAck,
  output logic                      wordValid,
  output bdDecoderPkg::outPayload_t word,
  input  logic                      wordAck
);

  import bdDecoderPkg::*;

  deserState_t state;
  amChunk_t    lowChunk;
  amChunk_t    highChunk;

  //////////////////////////////////////////////////
  // handshake from state
  //////////////////////////////////////////////////

  // chunks taken in WaitLow and WaitHigh only
  assign chunkAck  = (state != Full);
  // joined word held until acked
  assign wordValid = (state == Full);
  // second chunk lands above the first
  assign word      = {highChunk, lowChunk};

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      // drops any half-built word
      state <= WaitLow;
    end else begin
      case (state)
        WaitLow: begin
          if (chunkValid) state <= WaitHigh;
        end
        WaitHigh: begin
          if (chunkValid) state <= Full;
        end
        Full: begin
          // free again once the merge takes it
          if (wordAck) state <= WaitLow;
        end
        default: state <= WaitLow;
      endcase
    end
  end

  // chunk storage
  always_ff @(posedge clk) begin
    if (chunkValid && (state == WaitLow)) lowChunk <= chunk;
    if (chunkValid && (state == WaitHigh)) highChunk <= chunk;
  end

endmodule

/* tb.f */
+incdir+common
common/bdDecoderPkg.sv
bdHornDecoder/bdHornDecoder.sv
rtl/wordDeserializer.sv
rtl/streamMerge.sv
bdHornDeserializer/bdHornDeserializer.sv
rtl/bdDecoder.sv
test/bdDecoder_checker.sv
test/bdDecoderTb.sv

/* test/bdDecoderTb.sv */
`timescale 1ns/1ps
`include "bdDecoder_params.svh"

module bdDecoderTb;

  import bdDecoderPkg::*;

  localparam int MergeW = `BD_CODE_W + `BD_OUT_PAYLOAD_W;
  // well under 1000 cycles of traffic with ample margin
  localparam int TimeoutCycles = 4000;

  //////////////////////////////////////////////////
  // reference route table with routes right-aligned
  //////////////////////////////////////////////////
  localparam logic [0:`BD_NUM_LEAVES-1][6:0] RefRoute = '{
    7'h28, 7'h29, 7'h15, 7'h2e, 7'h2f, 7'h2d, 7'h08, 7'h09, 7'h03, 7'h58, 7'h59, 7'h01, 7'h00
  };
  localparam logic [0:`BD_NUM_LEAVES-1][2:0] RefLen = '{
    3'd6, 3'd6, 3'd5, 3'd6, 3'd6, 3'd6, 3'd4, 3'd4, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2
  };

  logic        clk = 1'b0;
  logic        rst;
  logic        inValid;
  bdWord_t     inWord;
  logic        inAck;
  logic        outValid;
  leafCode_t   outCode;
  outPayload_t outPayload;
  logic        outAck;

  int       seed = 74;
  int       errors = 0;
  int       expCount = 0;
  int       gotCount = 0;
  int       cycleCount = 0;
  string    testName = "idle";
  // first AM chunk waiting for its partner
  logic     haveLow = 1'b0;
  amChunk_t lowChunk;
  logic     stallPhase = 1'b0;
  logic     sawInAckLow = 1'b0;
  logic     streamDone;
  // expected {code, payload} per stream
  logic [MergeW-1:0] amQ[$];
  logic [MergeW-1:0] otherQ[$];

  bdDecoder uut (.*);

  bind bdDecoder bdDecoder_checker chk (
    .clk(clk), .rst(rst), .inValid(inValid), .inAck(inAck), .inWord(inWord),
    .outValid(outValid), .outAck(outAck), .outCode(outCode), .outPayload(outPayload)
  );

  initial forever #4 clk = ~clk;

  //////////////////////////////////////////////////
  // reference model and stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic [MergeW-1:0] expectWord(input bdWord_t w);
    int                len;
    logic              found;
    bdWord_t           keep;
    logic [MergeW-1:0] res;
    found = 1'b0;
    // low bits untouched when no route hits
    res = {leafCode_t'(Invalid), outPayload_t'(w[31:0])};
    for (int i = 0; i < `BD_NUM_LEAVES; i++) begin
      len = int'(RefLen[i]);
      if (!found && (w >> (`BD_WORD_W - len)) == bdWord_t'(RefRoute[i])) begin
        found = 1'b1;
        keep  = (bdWord_t'(1) << (`BD_WORD_W - len)) - bdWord_t'(1);
        res   = {leafCode_t'(i), outPayload_t'(w[31:0] & keep[31:0])};
      end
    end
    return res;
  endfunction

  function automatic bdWord_t randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[1:0], lo};
  endfunction

  // leaf route on top with fill below it
  function automatic bdWord_t makeWord(input int leaf, input bdWord_t fill);
    int len;
    len = int'(RefLen[leaf]);
    return (bdWord_t'(RefRoute[leaf]) << (`BD_WORD_W - len)) |
           (fill & ((bdWord_t'(1) << (`BD_WORD_W - len)) - bdWord_t'(1)));
  endfunction

  // AM chunks about half the time
  function automatic bdWord_t randomLeafWord();
    bdWord_t fill;
    int      leaf;
    fill = randWord();
    leaf = fill[8] ? 0 : (int'(fill[7:0]) % 12) + 1;
    return makeWord(leaf, fill);
  endfunction

  task automatic compare(input string stream, input logic [MergeW-1:0] want,
                         input logic [MergeW-1:0] got);
    if (got !== want) begin
      $display("CHECK FAILED %s (%s): expected %h, actual %h", testName, stream, want, got);
      errors++;
    end
  endtask

  // starts at a falling edge and holds the word until taken
  task automatic sendWord(input bdWord_t w);
    inValid = 1'b1;
    inWord  = w;
    @(posedge clk);
    while (!inAck) @(posedge clk);
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic sendAny(input bdWord_t w);
    logic [MergeW-1:0] want;
    want = expectWord(w);
    if (want[MergeW-1 -: `BD_CODE_W] == leafCode_t'(DumpAm)) begin
      // second chunk goes above the first
      if (haveLow) begin
        amQ.push_back({leafCode_t'(DumpAm), want[`BD_AM_CHUNK_W-1:0], lowChunk});
        expCount++;
      end else begin
        lowChunk = want[`BD_AM_CHUNK_W-1:0];
      end
      haveLow = !haveLow;
    end else begin
      otherQ.push_back(want);
      expCount++;
    end
    sendWord(w);
  endtask

  task automatic closePair();
    if (haveLow) sendAny(makeWord(0, randWord()));
  endtask

  task automatic waitDrain();
    while (amQ.size() + otherQ.size() > 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic leafTest();
    testName = "leafTest";
    for (int i = 0; i < `BD_NUM_LEAVES; i++) sendAny(makeWord(i, randWord()));
    // partner for the DumpAm word
    closePair();
    waitDrain();
  endtask

  task automatic unroutedTest();
    bdWord_t fill;
    testName = "unroutedTest";
    fill = randWord();
    // the table copy decides which leaf 1011010 lands on
    sendAny({7'b1011010, fill[26:0]});
    waitDrain();
  endtask

  task automatic amPairTest();
    testName = "amPairTest";
    for (int i = 0; i < 16; i++) sendAny(makeWord(0, randWord()));
    waitDrain();
  endtask

  task automatic stallTest();
    logic [31:0] r;
    testName    = "stallTest";
    stallPhase  = 1'b1;
    streamDone  = 1'b0;
    fork
      begin
        for (int i = 0; i < 40; i++) sendAny(randomLeafWord());
        closePair();
        streamDone = 1'b1;
      end
      begin
        // sink on or off for 1 to 8 cycles
        while (!streamDone) begin
          r      = $random(seed);
          outAck = r[0];
          repeat (int'(r[3:1]) + 1) @(negedge clk);
        end
        outAck = 1'b1;
      end
    join
    waitDrain();
    stallPhase = 1'b0;
    if (!sawInAckLow) begin
      $display("%s: inAck never dropped while the pipeline was full", testName);
      errors++;
    end
  endtask

  task automatic randomMixTest();
    int startExp;
    int startGot;
    testName = "randomMixTest";
    startExp = expCount;
    startGot = gotCount;
    for (int i = 0; i < 200; i++) sendAny(randomLeafWord());
    closePair();
    waitDrain();
    if (gotCount - startGot != expCount - startExp) begin
      $display("CHECK FAILED %s (count): expected %0d, actual %0d", testName,
               expCount - startExp, gotCount - startGot);
      errors++;
    end
  endtask

  task automatic resetTest();
    testName = "resetTest";
    // lone chunk that the reset drops
    sendWord(makeWord(0, randWord()));
    repeat (2) @(negedge clk);
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    sendAny(makeWord(0, randWord()));
    sendAny(makeWord(0, randWord()));
    waitDrain();
  endtask

  // scoreboard keeps each stream in its own order
  always @(posedge clk) begin : scoreboard
    logic [MergeW-1:0] got;
    logic [MergeW-1:0] want;
    got = {outCode, outPayload};
    // input refused while the output register is held
    if (stallPhase && inValid && !inAck && outValid && !outAck) sawInAckLow = 1'b1;
    if (!rst && outValid && outAck) begin
      gotCount++;
      if (outCode == leafCode_t'(DumpAm) && amQ.size() > 0) begin
        want = amQ.pop_front();
        compare("AM", want, got);
      end else if (outCode != leafCode_t'(DumpAm) && otherQ.size() > 0) begin
        want = otherQ.pop_front();
        compare("other", want, got);
      end else begin
        $display("%s: code %0d came out with nothing expected on its stream", testName,
                 outCode);
        errors++;
      end
    end
  end

  initial begin
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run still busy after %0d cycles", cycleCount);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst     = 1'b1;
    inValid = 1'b0;
    inWord  = '0;
    outAck  = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    leafTest();
    unroutedTest();
    amPairTest();
    stallTest();
    randomMixTest();
    resetTest();
    errors = errors + uut.chk.failCount;
    $display("errors: %0d, words expected: %0d, words seen: %0d", errors, expCount, gotCount);
    if (errors == 0 && gotCount == expCount) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* test/bdDecoder_checker.sv */
`timescale 1ns/1ps

module bdDecoder_checker (
  input logic                      clk,
  input logic                      rst,
  input logic                      inValid,
  input logic                      inAck,
  input bdDecoderPkg::bdWord_t     inWord,
  input logic                      outValid,
  input logic                      outAck,
  input bdDecoderPkg::leafCode_t   outCode,
  input bdDecoderPkg::outPayload_t outPayload
);

  import bdDecoderPkg::*;

  // failed assertions so far
  int failCount = 0;

  // merge register cleared by every reset edge
  resetClearsOut: assert property (@(posedge clk) $past(rst) |-> !outValid)
    else begin
      failCount++;
      $error("outValid high after a reset edge");
    end

  // held word frozen while the sink stalls
  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
    ($past(outValid && !outAck) && !$past(rst)) |->
      (outValid && $stable(outCode) && $stable(outPayload)))
    else begin
      failCount++;
      $error("output changed under a stall");
    end

  // no code above Invalid
  codeInRange: assert property (@(posedge clk) disable iff (rst)
    outValid |-> (outCode <= leafCode_t'(Invalid)))
    else begin
      failCount++;
      $error("outCode %0d out of range", outCode);
    end

  // full pipeline, same word, sink still stalled
  noAckUnderStall: assert property (@(posedge clk) disable iff (rst)
    ($past(inValid && !inAck && outValid && !outAck) && inValid && !outAck &&
     $stable(inWord)) |-> !inAck)
    else begin
      failCount++;
      $error("inAck rose while the pipeline was stalled");
    end

endmodule
